/* verilog.f */
+incdir+.
decoder_pkg.sv
imm_gen.sv
ctrl_decode.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_tb.sv

/* Makefile */
SIM  = obj_dir/Vdecode_stage_tb
SRCS = $(shell grep -v '^+' verilog.f) decoder_settings.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module decode_stage_tb -f verilog.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
		echo "$$out" | grep -q '^Simulation completed successfully$$'

clean:
	rm -rf obj_dir

/* decode_stage_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "decoder_settings.svh"

module decode_stage_tb;

    typedef struct packed {
        decoder_pkg::instr_t inst;
        decoder_pkg::pc_t    pc;
        logic                valid;
        decoder_pkg::uop_t   exp;
    } entry_t;

    logic                clock;
    logic                rst_n;
    logic                instr_valid;
    decoder_pkg::instr_t inst;
    decoder_pkg::pc_t    pc;
    logic                dec_valid;
    decoder_pkg::instr_t dec_inst;
    decoder_pkg::pc_t    dec_pc;
    decoder_pkg::uop_t   uop;

    entry_t entries[$];
    entry_t prev;
    logic   force_neg;
    int     errors;
    int     checks;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    decode_stage uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .inst        (inst),
        .pc          (pc),
        .dec_valid   (dec_valid),
        .dec_inst    (dec_inst),
        .dec_pc      (dec_pc),
        .uop         (uop)
    );

    function automatic decoder_pkg::ctrl_t alu_flags(input int pos, input logic imm_form,
                                                     input logic word, input logic uns);
        decoder_pkg::ctrl_t c;
        c               = '0;
        c.alu_type[pos] = 1'b1;
        c.need_to_wb    = 1'b1;
        c.is_imm        = imm_form;
        c.is_word       = word;
        c.is_unsigned   = uns;
        return c;
    endfunction

    function automatic decoder_pkg::ctrl_t cx_flags(input int pos, input logic uns,
                                                    input logic wb);
        decoder_pkg::ctrl_t c;
        c              = '0;
        c.cx_type[pos] = 1'b1;
        c.is_unsigned  = uns;
        c.need_to_wb   = wb;
        return c;
    endfunction

    function automatic decoder_pkg::ctrl_t mem_flags(input int pos, input logic load,
                                                     input logic uns);
        decoder_pkg::ctrl_t c;
        c              = '0;
        c.ls_size[pos] = 1'b1;
        c.is_load      = load;
        c.is_store     = ~load;
        c.need_to_wb   = load;
        c.is_unsigned  = uns;
        return c;
    endfunction

    function automatic decoder_pkg::ctrl_t md_flags(input int pos, input logic word);
        decoder_pkg::ctrl_t c;
        c                  = '0;
        c.muldiv_type[pos] = 1'b1;
        c.need_to_wb       = 1'b1;
        c.is_word          = word;
        return c;
    endfunction

    // ALU operation by funct3, alt selects SUB and SRA
    function automatic int alu_pos(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:       return alt ? `IS_SUB : `IS_ADD;
            3'd1:       return `IS_SLL;
            3'd2, 3'd3: return `IS_SLT;
            3'd4:       return `IS_XOR;
            3'd5:       return alt ? `IS_SRA : `IS_SRL;
            3'd6:       return `IS_OR;
            default:    return `IS_AND;
        endcase
    endfunction

    // Encodes a random immediate into the format and keeps its value as the expectation
    task automatic add_entry(input logic [6:0] op, input decoder_pkg::imm_fmt_e fmt,
                             input logic [2:0] f3, input logic [6:0] f7, input logic keep_f7,
                             input decoder_pkg::ctrl_t flags);
        entry_t      e;
        logic [31:0] r;
        logic [20:0] v;
        r = $urandom;
        v = 21'($urandom);
        case (fmt)
            decoder_pkg::IMM_I: begin
                v[11] = force_neg;
                if (keep_f7) begin
                    v[11:5] = f7;
                end
                e.inst    = {v[11:0], r[9:5], f3, r[4:0], op};
                e.exp.imm = {{52{v[11]}}, v[11:0]};
            end
            decoder_pkg::IMM_S: begin
                v[11]     = force_neg;
                e.inst    = {v[11:5], r[14:10], r[9:5], f3, v[4:0], op};
                e.exp.imm = {{52{v[11]}}, v[11:0]};
            end
            decoder_pkg::IMM_B: begin
                v[12]     = force_neg;
                v[0]      = 1'b0;
                e.inst    = {v[12], v[10:5], r[14:10], r[9:5], f3, v[4:1], v[11], op};
                e.exp.imm = {{51{v[12]}}, v[12:0]};
            end
            decoder_pkg::IMM_U: begin
                v[19]     = force_neg;
                e.inst    = {v[19:0], r[4:0], op};
                e.exp.imm = {{32{v[19]}}, v[19:0], 12'd0};
            end
            decoder_pkg::IMM_J: begin
                v[20]     = force_neg;
                v[0]      = 1'b0;
                e.inst    = {v[20], v[10:1], v[11], v[19:12], r[4:0], op};
                e.exp.imm = {{43{v[20]}}, v[20:0]};
            end
            default: begin
                e.inst    = {f7, r[14:10], r[9:5], f3, r[4:0], op};
                e.exp.imm = '0;
            end
        endcase
        e.exp.ctrl      = flags;
        e.exp.ctrl.lrs1 = e.inst[19:15];
        e.exp.ctrl.lrs2 = e.inst[24:20];
        e.exp.ctrl.lrd  = e.inst[11:7];
        e.pc            = {16'($urandom), 32'($urandom)};
        e.valid         = 1'b1;
        entries.push_back(e);
    endtask

    task automatic add_bubble();
        entry_t e;
        e.inst  = $urandom;
        e.pc    = {16'($urandom), 32'($urandom)};
        e.valid = 1'b0;
        e.exp   = '0;
        entries.push_back(e);
    endtask

    task automatic build_table();
        decoder_pkg::ctrl_t flags;
        for (int pass = 0; pass < 2; pass++) begin
            force_neg = pass[0];
            add_entry(`OPCODE_LUI, decoder_pkg::IMM_U, 3'd0, 7'd0, 1'b0,
                      alu_flags(`IS_LUI, 1'b0, 1'b0, 1'b0));
            add_entry(`OPCODE_AUIPC, decoder_pkg::IMM_U, 3'd0, 7'd0, 1'b0,
                      alu_flags(`IS_AUIPC, 1'b0, 1'b0, 1'b0));
            add_entry(`OPCODE_JAL, decoder_pkg::IMM_J, 3'd0, 7'd0, 1'b0,
                      cx_flags(`IS_JAL, 1'b0, 1'b1));
            add_entry(`OPCODE_JALR, decoder_pkg::IMM_I, 3'd0, 7'd0, 1'b0,
                      cx_flags(`IS_JALR, 1'b0, 1'b1));
            add_bubble();
            for (int f = 0; f < 8; f++) begin
                if (f == 2 || f == 3) continue;
                // BLTU and BGEU share the signed bits
                add_entry(`OPCODE_BRANCH, decoder_pkg::IMM_B, 3'(f), 7'd0, 1'b0,
                          cx_flags(f < 2 ? `IS_BEQ + f : `IS_BLT + f % 2, f >= 6, 1'b0));
            end
            for (int f = 0; f < 7; f++) begin
                add_entry(`OPCODE_LOAD, decoder_pkg::IMM_I, 3'(f), 7'd0, 1'b0,
                          mem_flags(`IS_B + f % 4, 1'b1, f >= 4));
            end
            for (int f = 0; f < 4; f++) begin
                add_entry(`OPCODE_STORE, decoder_pkg::IMM_S, 3'(f), 7'd0, 1'b0,
                          mem_flags(`IS_B + f, 1'b0, 1'b0));
            end
            add_bubble();
            for (int w = 0; w < 2; w++) begin
                for (int f = 0; f < 8; f++) begin
                    // Word ALU forms exist only for ADD, SUB and the shifts
                    if (w == 0 || f == 0 || f == 1 || f == 5) begin
                        add_entry(w == 1 ? `OPCODE_ALU_ITYPE_WORD : `OPCODE_ALU_ITYPE,
                                  decoder_pkg::IMM_I, 3'(f), 7'd0, f == 1 || f == 5,
                                  alu_flags(alu_pos(3'(f), 1'b0), 1'b1, w[0], f == 3));
                        add_entry(w == 1 ? `OPCODE_ALU_RTYPE_WORD : `OPCODE_ALU_RTYPE,
                                  decoder_pkg::IMM_NONE, 3'(f), 7'd0, 1'b0,
                                  alu_flags(alu_pos(3'(f), 1'b0), 1'b0, w[0], f == 3));
                        if (f == 0 || f == 5) begin
                            add_entry(w == 1 ? `OPCODE_ALU_RTYPE_WORD : `OPCODE_ALU_RTYPE,
                                      decoder_pkg::IMM_NONE, 3'(f), 7'b0100000, 1'b0,
                                      alu_flags(alu_pos(3'(f), 1'b1), 1'b0, w[0], 1'b0));
                        end
                    end
                    if (w == 1 && (f == 1 || f == 2 || f == 3)) continue;
                    add_entry(w == 1 ? `OPCODE_ALU_RTYPE_WORD : `OPCODE_ALU_RTYPE,
                              decoder_pkg::IMM_NONE, 3'(f), 7'b0000001, 1'b0,
                              md_flags(w == 0 ? `IS_MUL + f :
                                       (f == 0 ? `IS_MULW : `IS_DIVW + f - 4), w[0]));
                end
            end
            // Bit 25 is part of the shift amount
            add_entry(`OPCODE_ALU_ITYPE, decoder_pkg::IMM_I, 3'd5, 7'b0100000, 1'b1,
                      alu_flags(`IS_SRA, 1'b1, 1'b0, 1'b0));
            add_entry(`OPCODE_ALU_ITYPE, decoder_pkg::IMM_I, 3'd5, 7'b0100001, 1'b1,
                      alu_flags(`IS_SRA, 1'b1, 1'b0, 1'b0));
            add_entry(`OPCODE_ALU_ITYPE_WORD, decoder_pkg::IMM_I, 3'd5, 7'b0100000, 1'b1,
                      alu_flags(`IS_SRA, 1'b1, 1'b1, 1'b0));
            flags            = '0;
            flags.need_to_wb = 1'b1;
            add_entry(`OPCODE_ALU_RTYPE, decoder_pkg::IMM_NONE, 3'd1, 7'b0100000, 1'b0, flags);
            add_entry(`OPCODE_FENCE, decoder_pkg::IMM_NONE, 3'd0, 7'd0, 1'b0, '0);
            add_entry(`OPCODE_ENV, decoder_pkg::IMM_NONE, 3'd0, 7'd0, 1'b0, '0);
            add_entry(7'b1111111, decoder_pkg::IMM_NONE, 3'd2, 7'd5, 1'b0, '0);
            add_bubble();
            add_bubble();
        end
    endtask

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_entry(input entry_t e);
        compare("dec_valid", 128'(e.valid), 128'(dec_valid));
        compare("dec_inst", e.valid ? 128'(e.inst) : 128'd0, 128'(dec_inst));
        compare("dec_pc", e.valid ? 128'(e.pc) : 128'd0, 128'(dec_pc));
        compare("uop.ctrl", 128'(e.exp.ctrl), 128'(uop.ctrl));
        compare("uop.imm", 128'(e.exp.imm), 128'(uop.imm));
    endtask

    initial begin
        entry_t idle;
        int     wait_cycles;
        errors      = 0;
        checks      = 0;
        wait_cycles = 0;
        idle        = '0;
        void'($urandom(61452));
        instr_valid <= 1'b0;
        inst        <= '0;
        pc          <= '0;
        build_table();

        // A valid instruction sits on the inputs during reset
        prev = entries.pop_front();
        @(posedge clock);
        instr_valid <= prev.valid;
        inst        <= prev.inst;
        pc          <= prev.pc;
        do begin
            @(negedge clock);
            check_entry(idle);
            wait_cycles++;
        end while (rst_n !== 1'b1 && wait_cycles < 20);

        if (rst_n === 1'b1) begin
            foreach (entries[i]) begin
                @(posedge clock);
                instr_valid <= entries[i].valid;
                inst        <= entries[i].inst;
                pc          <= entries[i].pc;
                @(negedge clock);
                check_entry(prev);
                prev = entries[i];
            end
            @(posedge clock);
            instr_valid <= 1'b0;
            @(negedge clock);
            check_entry(prev);
        end else begin
            errors++;
            $display("Timeout: reset was not released within 20 clock cycles");
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
    end

    // 40 ns period
    always begin
        #20 clock = ~clock;
    end

    // Reset held low for four rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "decoder_settings.svh"

module decode_stage (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 instr_valid,
    input  decoder_pkg::instr_t inst,
    input  decoder_pkg::pc_t    pc,
    output logic                dec_valid,
    output decoder_pkg::instr_t dec_inst,
    output decoder_pkg::pc_t    dec_pc,
    output decoder_pkg::uop_t   uop
);

    decoder_pkg::ctrl_t    ctrl;
    decoder_pkg::imm_fmt_e imm_fmt;
    decoder_pkg::xlen_t    imm;
    decoder_pkg::uop_t     uop_next;

    ctrl_decode u_ctrl_decode (
        .inst    (inst),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    assign uop_next.ctrl = ctrl;
    assign uop_next.imm  = imm;

    // Stage register, a bubble leaves everything at zero
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_inst  <= '0;
            dec_pc    <= '0;
            uop       <= '0;
        end else if (instr_valid) begin
            dec_valid <= 1'b1;
            dec_inst  <= inst;
            dec_pc    <= pc;
            uop       <= uop_next;
        end else begin
            dec_valid <= 1'b0;
            dec_inst  <= '0;
            dec_pc    <= '0;
            uop       <= '0;
        end
    end

endmodule

`default_nettype wire

/* ctrl_decode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "decoder_settings.svh"

module ctrl_decode (
    input  decoder_pkg::instr_t   inst,
    output decoder_pkg::ctrl_t    ctrl,
    output decoder_pkg::imm_fmt_e imm_fmt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl      = '0;
        imm_fmt   = decoder_pkg::IMM_NONE;

        // Register fields pass through for every opcode
        ctrl.lrs1 = inst[19:15];
        ctrl.lrs2 = inst[24:20];
        ctrl.lrd  = inst[11:7];

        case (opcode)
            `OPCODE_LUI: begin
                imm_fmt                 = decoder_pkg::IMM_U;
                ctrl.alu_type[`IS_LUI]  = 1'b1;
                ctrl.need_to_wb         = 1'b1;
            end
            `OPCODE_AUIPC: begin
                imm_fmt                  = decoder_pkg::IMM_U;
                ctrl.alu_type[`IS_AUIPC] = 1'b1;
                ctrl.need_to_wb          = 1'b1;
            end
            `OPCODE_JAL: begin
                imm_fmt                = decoder_pkg::IMM_J;
                ctrl.cx_type[`IS_JAL]  = 1'b1;
                ctrl.need_to_wb        = 1'b1;
            end
            `OPCODE_JALR: begin
                imm_fmt                = decoder_pkg::IMM_I;
                ctrl.cx_type[`IS_JALR] = 1'b1;
                ctrl.need_to_wb        = 1'b1;
            end
            `OPCODE_BRANCH: begin
                imm_fmt = decoder_pkg::IMM_B;
                case (funct3)
                    3'b000: ctrl.cx_type[`IS_BEQ] = 1'b1;
                    3'b001: ctrl.cx_type[`IS_BNE] = 1'b1;
                    3'b100: ctrl.cx_type[`IS_BLT] = 1'b1;
                    3'b101: ctrl.cx_type[`IS_BGE] = 1'b1;
                    3'b110: begin
                        ctrl.cx_type[`IS_BLT] = 1'b1;
                        ctrl.is_unsigned      = 1'b1;
                    end
                    3'b111: begin
                        ctrl.cx_type[`IS_BGE] = 1'b1;
                        ctrl.is_unsigned      = 1'b1;
                    end
                    default: ;
                endcase
            end
            `OPCODE_LOAD: begin
                imm_fmt         = decoder_pkg::IMM_I;
                ctrl.is_load    = 1'b1;
                ctrl.need_to_wb = 1'b1;
                // Low two funct3 bits give the size, bit 2 zero-extends
                case (funct3)
                    3'b000, 3'b100: ctrl.ls_size[`IS_B] = 1'b1;
                    3'b001, 3'b101: ctrl.ls_size[`IS_H] = 1'b1;
                    3'b010, 3'b110: ctrl.ls_size[`IS_W] = 1'b1;
                    3'b011:         ctrl.ls_size[`IS_D] = 1'b1;
                    default: ;
                endcase
                if (funct3 inside {3'b100, 3'b101, 3'b110}) begin
                    ctrl.is_unsigned = 1'b1;
                end
            end
            `OPCODE_STORE: begin
                imm_fmt       = decoder_pkg::IMM_S;
                ctrl.is_store = 1'b1;
                case (funct3)
                    3'b000: ctrl.ls_size[`IS_B] = 1'b1;
                    3'b001: ctrl.ls_size[`IS_H] = 1'b1;
                    3'b010: ctrl.ls_size[`IS_W] = 1'b1;
                    3'b011: ctrl.ls_size[`IS_D] = 1'b1;
                    default: ;
                endcase
            end
            `OPCODE_ALU_ITYPE: begin
                imm_fmt         = decoder_pkg::IMM_I;
                ctrl.need_to_wb = 1'b1;
                // Bit 25 is shamt[5] on RV64 shifts
                casez ({funct7, funct3})
                    10'b???????_000: ctrl.alu_type[`IS_ADD] = 1'b1;
                    10'b???????_100: ctrl.alu_type[`IS_XOR] = 1'b1;
                    10'b???????_110: ctrl.alu_type[`IS_OR]  = 1'b1;
                    10'b???????_111: ctrl.alu_type[`IS_AND] = 1'b1;
                    10'b???????_010: ctrl.alu_type[`IS_SLT] = 1'b1;
                    10'b???????_011: begin
                        ctrl.alu_type[`IS_SLT] = 1'b1;
                        ctrl.is_unsigned       = 1'b1;
                    end
                    10'b000000?_001: ctrl.alu_type[`IS_SLL] = 1'b1;
                    10'b000000?_101: ctrl.alu_type[`IS_SRL] = 1'b1;
                    10'b010000?_101: ctrl.alu_type[`IS_SRA] = 1'b1;
                    default: ;
                endcase
                ctrl.is_imm = |ctrl.alu_type;
            end
            `OPCODE_ALU_ITYPE_WORD: begin
                imm_fmt         = decoder_pkg::IMM_I;
                ctrl.is_word    = 1'b1;
                ctrl.need_to_wb = 1'b1;
                casez ({funct7, funct3})
                    10'b???????_000: ctrl.alu_type[`IS_ADD] = 1'b1;
                    10'b0000000_001: ctrl.alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_101: ctrl.alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: ctrl.alu_type[`IS_SRA] = 1'b1;
                    default: ;
                endcase
                ctrl.is_imm = |ctrl.alu_type;
            end
            `OPCODE_ALU_RTYPE: begin
                ctrl.need_to_wb = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_type[`IS_ADD] = 1'b1;
                    10'b0100000_000: ctrl.alu_type[`IS_SUB] = 1'b1;
                    10'b0000000_001: ctrl.alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_010: ctrl.alu_type[`IS_SLT] = 1'b1;
                    10'b0000000_011: begin
                        ctrl.alu_type[`IS_SLT] = 1'b1;
                        ctrl.is_unsigned       = 1'b1;
                    end
                    10'b0000000_100: ctrl.alu_type[`IS_XOR] = 1'b1;
                    10'b0000000_101: ctrl.alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: ctrl.alu_type[`IS_SRA] = 1'b1;
                    10'b0000000_110: ctrl.alu_type[`IS_OR]  = 1'b1;
                    10'b0000000_111: ctrl.alu_type[`IS_AND] = 1'b1;
                    // M extension
                    10'b0000001_000: ctrl.muldiv_type[`IS_MUL]    = 1'b1;
                    10'b0000001_001: ctrl.muldiv_type[`IS_MULH]   = 1'b1;
                    10'b0000001_010: ctrl.muldiv_type[`IS_MULHSU] = 1'b1;
                    10'b0000001_011: ctrl.muldiv_type[`IS_MULHU]  = 1'b1;
                    10'b0000001_100: ctrl.muldiv_type[`IS_DIV]    = 1'b1;
                    10'b0000001_101: ctrl.muldiv_type[`IS_DIVU]   = 1'b1;
                    10'b0000001_110: ctrl.muldiv_type[`IS_REM]    = 1'b1;
                    10'b0000001_111: ctrl.muldiv_type[`IS_REMU]   = 1'b1;
                    default: ;
                endcase
            end
            `OPCODE_ALU_RTYPE_WORD: begin
                ctrl.is_word    = 1'b1;
                ctrl.need_to_wb = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_type[`IS_ADD] = 1'b1;
                    10'b0100000_000: ctrl.alu_type[`IS_SUB] = 1'b1;
                    10'b0000000_001: ctrl.alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_101: ctrl.alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: ctrl.alu_type[`IS_SRA] = 1'b1;
                    10'b0000001_000: ctrl.muldiv_type[`IS_MULW]  = 1'b1;
                    10'b0000001_100: ctrl.muldiv_type[`IS_DIVW]  = 1'b1;
                    10'b0000001_101: ctrl.muldiv_type[`IS_DIVUW] = 1'b1;
                    10'b0000001_110: ctrl.muldiv_type[`IS_REMW]  = 1'b1;
                    10'b0000001_111: ctrl.muldiv_type[`IS_REMUW] = 1'b1;
                    default: ;
                endcase
            end
            // System opcodes are not handled in this core
            `OPCODE_FENCE, `OPCODE_ENV: ;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* imm_gen.sv */
`default_nettype none
`timescale 1ns/1ps

`include "decoder_settings.svh"

module imm_gen (
    input  decoder_pkg::instr_t   inst,
    input  decoder_pkg::imm_fmt_e imm_fmt,
    output decoder_pkg::xlen_t    imm
);

    decoder_pkg::xlen_t imm_i;
    decoder_pkg::xlen_t imm_s;
    decoder_pkg::xlen_t imm_b;
    decoder_pkg::xlen_t imm_u;
    decoder_pkg::xlen_t imm_j;

    // All formats take their sign from bit 31
    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7],
                    inst[30:25], inst[11:8], 1'b0};

    // Upper immediate already sits at bit 12
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12],
                    inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            decoder_pkg::IMM_I: imm = imm_i;
            decoder_pkg::IMM_S: imm = imm_s;
            decoder_pkg::IMM_B: imm = imm_b;
            decoder_pkg::IMM_U: imm = imm_u;
            decoder_pkg::IMM_J: imm = imm_j;
            default:            imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* decoder_pkg.sv */
`default_nettype none

`include "decoder_settings.svh"

package decoder_pkg;

    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`PC_W-1:0]      pc_t;
    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // One-hot selectors
    typedef logic [`ALU_W-1:0]     alu_sel_t;
    typedef logic [`CX_W-1:0]      cx_sel_t;
    typedef logic [`LS_W-1:0]      ls_size_t;
    typedef logic [`MULDIV_W-1:0]  muldiv_sel_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    typedef struct packed {
        reg_idx_t    lrs1;
        reg_idx_t    lrs2;
        reg_idx_t    lrd;
        logic        need_to_wb;
        cx_sel_t     cx_type;
        logic        is_unsigned;
        alu_sel_t    alu_type;
        logic        is_word;
        logic        is_imm;
        logic        is_load;
        logic        is_store;
        ls_size_t    ls_size;
        muldiv_sel_t muldiv_type;
    } ctrl_t;

    // Full micro-op as seen by issue
    typedef struct packed {
        ctrl_t ctrl;
        xlen_t imm;
    } uop_t;

endpackage

`default_nettype wire

/* decoder_settings.svh */
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

`define XLEN        64
`define PC_W        48
`define INSTR_W     32
`define REG_IDX_W   5

// Major opcodes
`define OPCODE_LUI            7'b0110111
`define OPCODE_AUIPC          7'b0010111
`define OPCODE_JAL            7'b1101111
`define OPCODE_JALR           7'b1100111
`define OPCODE_BRANCH         7'b1100011
`define OPCODE_LOAD           7'b0000011
`define OPCODE_STORE          7'b0100011
`define OPCODE_ALU_ITYPE      7'b0010011
`define OPCODE_ALU_RTYPE      7'b0110011
`define OPCODE_FENCE          7'b0001111
`define OPCODE_ENV            7'b1110011
`define OPCODE_ALU_ITYPE_WORD 7'b0011011
`define OPCODE_ALU_RTYPE_WORD 7'b0111011

// Selector widths
`define ALU_W     11
`define CX_W      6
`define LS_W      4
`define MULDIV_W  13

// alu_type bits
`define IS_ADD    0
`define IS_SUB    1
`define IS_SLL    2
`define IS_SLT    3
`define IS_XOR    4
`define IS_SRL    5
`define IS_SRA    6
`define IS_OR     7
`define IS_AND    8
`define IS_LUI    9
`define IS_AUIPC  10

// cx_type bits, unsigned compares reuse BLT/BGE
`define IS_JAL    0
`define IS_JALR   1
`define IS_BEQ    2
`define IS_BNE    3
`define IS_BLT    4
`define IS_BGE    5

// ls_size bits
`define IS_B      0
`define IS_H      1
`define IS_W      2
`define IS_D      3

// muldiv_type bits
`define IS_MUL    0
`define IS_MULH   1
`define IS_MULHSU 2
`define IS_MULHU  3
`define IS_DIV    4
`define IS_DIVU   5
`define IS_REM    6
`define IS_REMU   7
`define IS_MULW   8
`define IS_DIVW   9
`define IS_DIVUW  10
`define IS_REMW   11
`define IS_REMUW  12

`endif
